// File: logic/core_macros.svh
// Width macros for the core datapath and the APB register port
// Reset defaults for the stage-1 vectors and fetch limit

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath widths
`define CORE_XLEN                   32      // Data word and byte address width
`define CORE_APB_ADDR_W             8       // APB register offset width

// Register reset values
`define CORE_RESET_VECTOR_DEFAULT   32'h0000_0000   // First fetch address
`define CORE_TRAP_VECTOR_DEFAULT    32'h0000_0100   // Fetch resumes here after an exception
`define CORE_FETCH_LIMIT_DEFAULT    32'h0000_0400   // Fetches at or above this trap

`endif

// File: logic/letc_pkg.sv
// Core-wide types
// Data word, byte address and APB register offset

`default_nettype none

`include "core_macros.svh"

package letc_pkg;

    // Datapath types
    typedef logic [`CORE_XLEN-1:0] word_t;      // Data word, also the APB data type
    typedef logic [`CORE_XLEN-1:0] addr_t;      // Byte address

    // APB register port
    typedef logic [`CORE_APB_ADDR_W-1:0] apb_addr_t; // Register offset within the block

endpackage : letc_pkg

`default_nettype wire

// File: logic/core_pkg.sv
// Stage-1 types for the core
// Instruction word union, control state enum
// LETC.EXIT encoding and register block offsets

`default_nettype none

package core_pkg;

    import letc_pkg::*;

    // Instruction fields in R-type order
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;     // Always the low bits
    } inst_fields_t;

    // One word, seen raw or as fields
    typedef union packed {
        word_t        raw;      // As read from memory
        inst_fields_t fields;   // As decoded
    } inst_u;

    // Stage-1 control states
    typedef enum logic [2:0] {
        INIT,                       // Waits for start
        HALT,                       // Left only by reset
        FETCHING,                   // Presents an item each cycle
        STALLED_ON_S2_NOEXCEPT,     // Holding a normal item
        STALLED_ON_S2_FETCHEXCEPT   // Holding an exception item
    } s1_state_e;

    // LETC.EXIT lives in the custom-0 space
    localparam logic [6:0] OPCODE_CUSTOM0 = 7'b000_1011;
    localparam logic [2:0] FUNCT3_EXIT    = 3'b000;

    // Register offsets
    localparam apb_addr_t REG_CTRL         = 8'h00;   // Bit 0 start
    localparam apb_addr_t REG_RESET_VECTOR = 8'h04;
    localparam apb_addr_t REG_TRAP_VECTOR  = 8'h08;
    localparam apb_addr_t REG_FETCH_LIMIT  = 8'h0C;
    localparam apb_addr_t REG_STATUS       = 8'h10;   // Read-only
    localparam apb_addr_t REG_ISSUE_COUNT  = 8'h14;   // Read-only
    localparam apb_addr_t REG_TRAP_COUNT   = 8'h18;   // Read-only

endpackage : core_pkg

`default_nettype wire

// File: logic/core_s1_control.sv
// Stage-1 control FSM
// Start wait, stall on stage 2, issue, trap redirect and halt

`timescale 1ns/1ps
`default_nettype none

module core_s1_control (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,            // From register block
    input  logic                  halt_req,         // Last accepted item was LETC.EXIT
    input  logic                  s2_busy,          // Stage 2 cannot take an item
    input  logic                  fetch_exception,  // Current item is an exception
    output logic                  s2_valid,
    output logic                  s1_stall,
    output logic                  init,             // Load reset vector
    output logic                  issue,            // Item accepted this cycle
    output logic                  trap_redirect,    // Exception item accepted
    output core_pkg::s1_state_e   state
);

    import core_pkg::*;

    s1_state_e state_ff;
    s1_state_e next_state;
    logic      item_exception;      // Exception flag of the item on offer

    always_ff @(posedge clk or negedge rst_n) begin : state_seq
        if (!rst_n) begin
            state_ff <= INIT;
        end else begin
            state_ff <= next_state;
        end
    end : state_seq

    always_comb begin : next_state_logic
        case (state_ff)
            INIT:     next_state = start ? FETCHING : INIT; // Software sets vectors first
            HALT:     next_state = HALT;                    // Only reset leaves
            FETCHING: begin
                if (halt_req) begin
                    next_state = HALT;                      // EXIT already handed over
                end else if (s2_busy) begin
                    next_state = fetch_exception ? STALLED_ON_S2_FETCHEXCEPT
                                                 : STALLED_ON_S2_NOEXCEPT;
                end else begin
                    next_state = FETCHING;
                end
            end
            STALLED_ON_S2_NOEXCEPT, STALLED_ON_S2_FETCHEXCEPT: begin
                next_state = s2_busy ? state_ff : FETCHING; // Accepted once busy drops
            end
            default:  next_state = HALT;                    // Illegal encoding
        endcase
    end : next_state_logic

    always_comb begin : handover_logic
        case (state_ff)
            FETCHING: begin
                s2_valid       = !halt_req;     // Nothing after EXIT
                item_exception = fetch_exception;
            end
            STALLED_ON_S2_NOEXCEPT: begin
                s2_valid       = 1'b1;          // Item still waiting
                item_exception = 1'b0;
            end
            STALLED_ON_S2_FETCHEXCEPT: begin
                s2_valid       = 1'b1;
                item_exception = 1'b1;          // Held exception item
            end
            default: begin
                s2_valid       = 1'b0;
                item_exception = 1'b0;
            end
        endcase
    end : handover_logic

    // Handover and pipeline control
    assign issue         = s2_valid && !s2_busy;        // Accept handshake
    assign trap_redirect = issue && item_exception;     // Next fetch from trap vector
    assign init          = state_ff == INIT;            // PC tracks reset vector
    assign s1_stall      = state_ff != FETCHING;
    assign state         = state_ff;

endmodule : core_s1_control

`default_nettype wire

// File: logic/core_s1_fetch.sv
// Stage-1 fetch datapath
// Program counter, instruction memory read, address checks
// LETC.EXIT decode and halt request flag

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_s1_fetch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              init,             // Load reset vector
    input  logic              issue,            // Item accepted, advance
    input  logic              trap_redirect,    // Exception accepted, go to trap
    input  letc_pkg::addr_t   reset_vector,
    input  letc_pkg::addr_t   trap_vector,
    input  letc_pkg::addr_t   fetch_limit,      // First disallowed address
    output letc_pkg::addr_t   imem_addr,
    input  letc_pkg::word_t   imem_rdata,       // Combinational read data
    output core_pkg::inst_u   s2_inst,
    output letc_pkg::addr_t   s2_pc,
    output logic              fetch_exception,
    output logic              halt_req
);

    import letc_pkg::*;
    import core_pkg::*;

    addr_t pc_ff;
    inst_u mem_inst;            // Memory word before exception masking
    logic  misaligned;
    logic  out_of_range;
    logic  is_exit;             // Word decodes as LETC.EXIT
    logic  halt_ff;

    // Program counter
    always_ff @(posedge clk or negedge rst_n) begin : pc_seq
        if (!rst_n) begin
            pc_ff <= `CORE_RESET_VECTOR_DEFAULT;
        end else if (init) begin
            pc_ff <= reset_vector;              // Follows software until start
        end else if (trap_redirect) begin
            pc_ff <= trap_vector;               // Takes priority over plain advance
        end else if (issue) begin
            pc_ff <= pc_ff + addr_t'(4);
        end
    end : pc_seq

    assign imem_addr = pc_ff;
    assign s2_pc     = pc_ff;

    // Address checks
    assign misaligned      = |pc_ff[1:0];
    assign out_of_range    = pc_ff >= fetch_limit;      // Window is [0, limit)
    assign fetch_exception = misaligned || out_of_range;

    // Instruction word
    always_comb begin : inst_logic
        mem_inst.raw = imem_rdata;
        if (fetch_exception) begin
            s2_inst.raw = '0;                   // Never pass a bad fetch's data on
        end else begin
            s2_inst.raw = mem_inst.raw;
        end
    end : inst_logic

    // EXIT decode on the field view
    assign is_exit = (mem_inst.fields.opcode == OPCODE_CUSTOM0)
                  && (mem_inst.fields.funct3 == FUNCT3_EXIT);

    // Sticky until reset, set by an accepted EXIT
    always_ff @(posedge clk or negedge rst_n) begin : halt_seq
        if (!rst_n) begin
            halt_ff <= 1'b0;
        end else if (issue && is_exit && !fetch_exception) begin
            halt_ff <= 1'b1;
        end
    end : halt_seq

    assign halt_req = halt_ff;

endmodule : core_s1_fetch

`default_nettype wire

// File: logic/core_s1_csr.sv
// Stage-1 APB register block
// Start bit, reset and trap vectors, fetch limit
// Status and issue/trap counters

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_s1_csr (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  letc_pkg::apb_addr_t   paddr,
    input  letc_pkg::word_t       pwdata,
    output letc_pkg::word_t       prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  core_pkg::s1_state_e   state,            // From control FSM
    input  logic                  issue,
    input  logic                  trap_redirect,
    output logic                  start,
    output letc_pkg::addr_t       reset_vector,
    output letc_pkg::addr_t       trap_vector,
    output letc_pkg::addr_t       fetch_limit
);

    import letc_pkg::*;
    import core_pkg::*;

    logic  access;              // APB access phase
    logic  wr_en;
    logic  addr_hit;            // Offset is mapped
    logic  halted;
    logic  start_ff;
    addr_t reset_vector_ff;
    addr_t trap_vector_ff;
    addr_t fetch_limit_ff;
    word_t issue_count_ff;
    word_t trap_count_ff;
    word_t status;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;       // Takes effect at end of access
    assign pready = access;                 // No wait states

    // Writable registers, read-only offsets fall through
    always_ff @(posedge clk or negedge rst_n) begin : rw_seq
        if (!rst_n) begin
            start_ff        <= 1'b0;
            reset_vector_ff <= `CORE_RESET_VECTOR_DEFAULT;
            trap_vector_ff  <= `CORE_TRAP_VECTOR_DEFAULT;
            fetch_limit_ff  <= `CORE_FETCH_LIMIT_DEFAULT;
        end else if (wr_en) begin
            case (paddr)
                REG_CTRL:         start_ff        <= pwdata[0];
                REG_RESET_VECTOR: reset_vector_ff <= pwdata;
                REG_TRAP_VECTOR:  trap_vector_ff  <= pwdata;
                REG_FETCH_LIMIT:  fetch_limit_ff  <= pwdata;
                default: ;
            endcase
        end
    end : rw_seq

    // Free-running counters, wrap at 2^32
    always_ff @(posedge clk or negedge rst_n) begin : count_seq
        if (!rst_n) begin
            issue_count_ff <= '0;
            trap_count_ff  <= '0;
        end else begin
            if (issue) issue_count_ff <= issue_count_ff + word_t'(1);
            if (trap_redirect) trap_count_ff <= trap_count_ff + word_t'(1);
        end
    end : count_seq

    assign halted = state == HALT;
    assign status = {{(`CORE_XLEN-4){1'b0}}, halted, state};

    // Read mux and decode
    always_comb begin : read_logic
        addr_hit = 1'b1;
        case (paddr)
            REG_CTRL:         prdata = {{(`CORE_XLEN-1){1'b0}}, start_ff};
            REG_RESET_VECTOR: prdata = reset_vector_ff;
            REG_TRAP_VECTOR:  prdata = trap_vector_ff;
            REG_FETCH_LIMIT:  prdata = fetch_limit_ff;
            REG_STATUS:       prdata = status;
            REG_ISSUE_COUNT:  prdata = issue_count_ff;
            REG_TRAP_COUNT:   prdata = trap_count_ff;
            default: begin
                prdata   = '0;
                addr_hit = 1'b0;          // Unmapped offset
            end
        endcase
    end : read_logic

    assign pslverr = access && !addr_hit;

    assign start        = start_ff;
    assign reset_vector = reset_vector_ff;
    assign trap_vector  = trap_vector_ff;
    assign fetch_limit  = fetch_limit_ff;

endmodule : core_s1_csr

`default_nettype wire

// File: logic/core_s1.sv
// Stage-1 top level
// Control FSM, fetch datapath and APB registers

`timescale 1ns/1ps
`default_nettype none

module core_s1 (
    input  logic                  clk,
    input  logic                  rst_n,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  letc_pkg::apb_addr_t   paddr,
    input  letc_pkg::word_t       pwdata,
    output letc_pkg::word_t       prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Instruction memory
    output letc_pkg::addr_t       imem_addr,
    input  letc_pkg::word_t       imem_rdata,
    // Stage 2 handover
    output logic                  s2_valid,
    output core_pkg::inst_u       s2_inst,
    output letc_pkg::addr_t       s2_pc,
    output logic                  s2_fetch_exception,
    input  logic                  s2_busy,
    output logic                  s1_stall
);

    import letc_pkg::*;
    import core_pkg::*;

    logic      start;
    logic      halt_req;
    logic      init;
    logic      issue;
    logic      trap_redirect;
    s1_state_e state;
    addr_t     reset_vector;
    addr_t     trap_vector;
    addr_t     fetch_limit;

    core_s1_control u_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .halt_req        (halt_req),
        .s2_busy         (s2_busy),
        .fetch_exception (s2_fetch_exception),  // Same net goes to stage 2
        .s2_valid        (s2_valid),
        .s1_stall        (s1_stall),
        .init            (init),
        .issue           (issue),
        .trap_redirect   (trap_redirect),
        .state           (state)
    );

    core_s1_fetch u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .init            (init),
        .issue           (issue),
        .trap_redirect   (trap_redirect),
        .reset_vector    (reset_vector),
        .trap_vector     (trap_vector),
        .fetch_limit     (fetch_limit),
        .imem_addr       (imem_addr),
        .imem_rdata      (imem_rdata),
        .s2_inst         (s2_inst),
        .s2_pc           (s2_pc),
        .fetch_exception (s2_fetch_exception),
        .halt_req        (halt_req)
    );

    core_s1_csr u_csr (
        .clk             (clk),
        .rst_n           (rst_n),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .state           (state),
        .issue           (issue),
        .trap_redirect   (trap_redirect),
        .start           (start),
        .reset_vector    (reset_vector),
        .trap_vector     (trap_vector),
        .fetch_limit     (fetch_limit)
    );

endmodule : core_s1

`default_nettype wire

// File: tests/core_s1_tb.sv
// Directed testbench for the stage-1 fetch top level
// Instruction memory model, APB tasks, stage-2 model with back-pressure
// Compare tasks, directed tests and watchdog

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_s1_tb;

    import letc_pkg::*;
    import core_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    // Worst case per test: regs, sequential, back-pressure, exceptions, halt
    localparam int WATCHDOG_CYCLES = 300 + 200 + 600 + 600 + 400 + 7 * RESET_CYCLES;
    localparam logic [1:0] BUSY_LOW    = 2'd0;
    localparam logic [1:0] BUSY_HIGH   = 2'd1;
    localparam logic [1:0] BUSY_RANDOM = 2'd2;

    logic      clk;
    logic      rst_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;
    addr_t     imem_addr;
    word_t     imem_rdata;
    logic      s2_valid;
    inst_u     s2_inst;
    addr_t     s2_pc;
    logic      s2_fetch_exception;
    logic      s2_busy;
    logic      s1_stall;

    word_t      mem [0:1023];       // 4 KiB instruction memory
    addr_t      acc_pc[$];          // Items accepted by stage 2
    inst_u      acc_inst[$];
    logic       acc_exc[$];
    addr_t      acc_imem[$];        // Memory address seen at acceptance
    logic [1:0] busy_mode;
    integer     seed;
    int         errors;
    int         wait_cycles;        // Cycles an item was seen waiting
    string      test_name;
    logic       last_err;           // pslverr of the last APB transfer
    logic       waiting;            // Item offered last cycle and not taken
    addr_t      held_pc;
    inst_u      held_inst;
    logic       held_exc;

    core_s1 DUT (.*);

    assign imem_rdata = mem[imem_addr[11:2]];   // Combinational read

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Opcode 0x33 keeps fill words clear of LETC.EXIT
    function automatic word_t fill_word(input addr_t a);
        return {a[31:7] ^ a[24:0] ^ 25'h0A5_A5A5, 7'h33};
    endfunction

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_addr(input string what, input addr_t expected, input addr_t actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_inst(input string what, input inst_u expected, input inst_u actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s %s: expected %h actual %h", test_name, what,
                     expected.raw, actual.raw);
        end
    endtask

    task automatic check_flag(input string what, input logic expected, input logic actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s %s: expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    // Stage-2 busy driver
    always @(posedge clk) begin : busy_drive
        integer rnd;
        #1;
        rnd = $random(seed);
        s2_busy = (busy_mode == BUSY_HIGH) || (busy_mode == BUSY_RANDOM && rnd[0]);
    end : busy_drive

    // Stage-2 model, samples mid-cycle
    always @(negedge clk) begin : stage2_model
        if (!rst_n) begin
            waiting = 1'b0;
        end else begin
            if (waiting) begin                                  // Item must hold steady
                wait_cycles++;
                check_flag("s1_stall while waiting", 1'b1, s1_stall);
                check_flag("held s2_valid", 1'b1, s2_valid);
                check_addr("held s2_pc", held_pc, s2_pc);
                check_inst("held s2_inst", held_inst, s2_inst);
                check_flag("held exception", held_exc, s2_fetch_exception);
            end
            if (s2_valid && !s2_busy) begin                     // Accepted this cycle
                acc_pc.push_back(s2_pc);
                acc_inst.push_back(s2_inst);
                acc_exc.push_back(s2_fetch_exception);
                acc_imem.push_back(imem_addr);
            end
            waiting   = s2_valid && s2_busy;
            held_pc   = s2_pc;
            held_inst = s2_inst;
            held_exc  = s2_fetch_exception;
        end
    end : stage2_model

    // Setup then access phase, no wait states
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input word_t wdata,
                            output word_t rdata);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_flag("pready", 1'b1, pready);
        rdata    = prdata;
        last_err = pslverr;
        @(posedge clk);                                     // Write lands here
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input word_t data);
        word_t unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input apb_addr_t addr, output word_t data);
        apb_xfer(1'b0, addr, '0, data);
    endtask

    task automatic read_check(input apb_addr_t addr, input word_t expected, input string what);
        word_t data;
        apb_read(addr, data);
        check_word(what, expected, data);
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        busy_mode = BUSY_HIGH;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        acc_pc.delete();
        acc_inst.delete();
        acc_exc.delete();
        acc_imem.delete();
        rst_n = 1'b1;
    endtask

    task automatic start_fetch(input addr_t vector, input logic [1:0] mode);
        apb_write(REG_RESET_VECTOR, vector);
        busy_mode = mode;
        apb_write(REG_CTRL, 32'h1);
    endtask

    task automatic wait_items(input int count, input int max_cycles);
        int n;
        n = 0;
        while (acc_pc.size() < count && n < max_cycles) begin
            @(posedge clk);
            n++;
        end
        if (acc_pc.size() < count) begin
            errors++;
            $display("ERROR %s: only %0d of %0d items accepted in %0d cycles",
                     test_name, acc_pc.size(), count, max_cycles);
        end
    endtask

    task automatic pause_stage2();
        busy_mode = BUSY_HIGH;
        repeat (3) @(posedge clk);                          // Let the last handover settle
    endtask

    // Exception items carry a zero instruction
    task automatic verify_item(input int idx, input addr_t pc, input logic exc);
        inst_u exp;
        exp.raw = exc ? '0 : mem[pc[11:2]];
        if (idx >= acc_pc.size()) begin
            errors++;
            $display("ERROR %s: item %0d was never accepted", test_name, idx);
        end else begin
            check_addr("item pc", pc, acc_pc[idx]);
            check_addr("item imem_addr", pc, acc_imem[idx]);
            check_inst("item inst", exp, acc_inst[idx]);
            check_flag("item exception", exc, acc_exc[idx]);
        end
    endtask

    task automatic reset_and_registers();
        word_t data;
        test_name = "reset_regs";
        check_flag("s2_valid after reset", 1'b0, s2_valid);
        read_check(REG_CTRL, '0, "ctrl");
        read_check(REG_RESET_VECTOR, `CORE_RESET_VECTOR_DEFAULT, "reset vector");
        read_check(REG_TRAP_VECTOR, `CORE_TRAP_VECTOR_DEFAULT, "trap vector");
        read_check(REG_FETCH_LIMIT, `CORE_FETCH_LIMIT_DEFAULT, "fetch limit");
        read_check(REG_STATUS, word_t'(INIT), "status");
        check_flag("pslverr mapped", 1'b0, last_err);
        apb_write(REG_STATUS, '1);                          // Read-only, ignored
        apb_write(REG_ISSUE_COUNT, '1);
        apb_write(REG_TRAP_COUNT, '1);
        check_flag("pslverr read-only write", 1'b0, last_err);
        read_check(REG_STATUS, word_t'(INIT), "status after write");
        read_check(REG_ISSUE_COUNT, '0, "issue count");
        read_check(REG_TRAP_COUNT, '0, "trap count");
        apb_read(8'h1C, data);
        check_flag("pslverr unmapped read", 1'b1, last_err);
        apb_write(8'hF0, 32'h1234_5678);
        check_flag("pslverr unmapped write", 1'b1, last_err);
    endtask

    task automatic sequential_fetch();
        int i;
        test_name = "seq_fetch";
        apply_reset();
        start_fetch(32'h40, BUSY_LOW);
        wait_items(8, 60);
        pause_stage2();
        for (i = 0; i < acc_pc.size(); i++) begin
            verify_item(i, addr_t'(32'h40 + 4 * i), 1'b0);
        end
        read_check(REG_ISSUE_COUNT, word_t'(acc_pc.size()), "issue count");
    endtask

    task automatic back_pressure();
        int i;
        test_name   = "backpressure";
        apply_reset();
        wait_cycles = 0;
        start_fetch(32'h200, BUSY_RANDOM);
        wait_items(20, 400);
        pause_stage2();
        for (i = 0; i < acc_pc.size(); i++) begin
            verify_item(i, addr_t'(32'h200 + 4 * i), 1'b0);
        end
        read_check(REG_ISSUE_COUNT, word_t'(acc_pc.size()), "issue count");
        if (wait_cycles == 0) begin
            errors++;
            $display("ERROR %s: random busy never made an item wait", test_name);
        end
    endtask

    task automatic fetch_exceptions();
        test_name = "exception_limit";
        apply_reset();
        apb_write(REG_FETCH_LIMIT, 32'h80);
        apb_write(REG_TRAP_VECTOR, 32'h20);                 // Inside the smaller window
        start_fetch(32'h78, BUSY_RANDOM);
        wait_items(5, 200);
        pause_stage2();
        verify_item(0, 32'h78, 1'b0);
        verify_item(1, 32'h7C, 1'b0);
        verify_item(2, 32'h80, 1'b1);                       // At the limit
        verify_item(3, 32'h20, 1'b0);
        verify_item(4, 32'h24, 1'b0);
        read_check(REG_TRAP_COUNT, 32'h1, "trap count");
        test_name = "exception_misaligned";
        apply_reset();
        start_fetch(32'h42, BUSY_HIGH);
        repeat (4) @(posedge clk);                          // Exception item held in a stall
        busy_mode = BUSY_LOW;
        wait_items(3, 60);
        pause_stage2();
        verify_item(0, 32'h42, 1'b1);
        verify_item(1, `CORE_TRAP_VECTOR_DEFAULT, 1'b0);
        verify_item(2, `CORE_TRAP_VECTOR_DEFAULT + 32'h4, 1'b0);
        read_check(REG_TRAP_COUNT, 32'h1, "trap count");
    endtask

    task automatic halt_on_exit();
        inst_u exit_inst;
        test_name = "halt";
        exit_inst.raw           = '0;
        exit_inst.fields.opcode = OPCODE_CUSTOM0;
        exit_inst.fields.funct3 = FUNCT3_EXIT;
        exit_inst.fields.rd     = 5'd1;
        exit_inst.fields.rs1    = 5'd2;
        mem[4] = exit_inst.raw;                             // EXIT at 0x10
        apply_reset();
        start_fetch(32'h08, BUSY_LOW);
        wait_items(3, 60);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_word("accepted items", 32'd3, word_t'(acc_pc.size()));
        verify_item(2, 32'h10, 1'b0);
        check_flag("s2_valid after exit", 1'b0, s2_valid);
        read_check(REG_STATUS, {28'h0, 1'b1, HALT}, "status");
        apb_write(REG_CTRL, 32'h0);
        apb_write(REG_CTRL, 32'h1);                         // Start again, no effect
        repeat (10) @(posedge clk);
        check_word("accepted items after start", 32'd3, word_t'(acc_pc.size()));
        read_check(REG_STATUS, {28'h0, 1'b1, HALT}, "status after start");
        apply_reset();
        read_check(REG_STATUS, word_t'(INIT), "status after reset");
        mem[4] = fill_word(32'h10);
    endtask

    initial begin : main
        seed        = 24;
        errors      = 0;
        wait_cycles = 0;
        waiting     = 1'b0;
        last_err    = 1'b0;
        test_name   = "init";
        busy_mode   = BUSY_HIGH;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        s2_busy     = 1'b1;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = fill_word(addr_t'(a * 4));
        end
        apply_reset();
        reset_and_registers();
        sequential_fetch();
        back_pressure();
        fetch_exceptions();
        halt_on_exit();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end : main

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR %s: watchdog expired after %0d cycles, tests did not finish",
                 test_name, WATCHDOG_CYCLES);
        $display("Errors: %0d", errors);
        $display("Result: FAILED");
        $finish;
    end : watchdog

endmodule : core_s1_tb

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/letc_pkg.sv
logic/core_pkg.sv
logic/core_s1_control.sv
logic/core_s1_fetch.sv
logic/core_s1_csr.sv
logic/core_s1.sv
tests/core_s1_tb.sv

// File: Bender.yml
package:
  name: core_s1

sources:
  - include_dirs:
      - logic
    files:
      - logic/letc_pkg.sv
      - logic/core_pkg.sv
      - logic/core_s1_control.sv
      - logic/core_s1_fetch.sv
      - logic/core_s1_csr.sv
      - logic/core_s1.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/core_s1_tb.sv
